// ==== all.f ====
+incdir+source
source/nic_pkg.sv
source/csr_regs.sv
source/intr_ctrl.sv
source/mdio_master.sv
source/nic_top.sv
tests/tb_nic_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_nic_top -f all.f -Mdir obj_dir -o tb_nic_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_nic_top > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "^Testbench passed$" "$log"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, exit status $run_status"
exit 1

// ==== tests/tb_nic_top.sv ====
`timescale 1ns/10ps
`include "nic_config.svh"

module tb_nic_top;
	import nic_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam logic [3:0] K_WR = 4'd0;
	localparam logic [3:0] K_RD = 4'd1;
	localparam logic [3:0] K_POLL = 4'd2; // Read until a masked bit is set
	localparam logic [3:0] K_INTR = 4'd3;
	localparam logic [3:0] K_PINS = 4'd4; // {phy_reset_o, rst_req_o}
	localparam logic [3:0] K_PHY = 4'd5;
	localparam logic [3:0] K_PIN = 4'd6;
	localparam logic [3:0] K_IDLE = 4'd7;

	typedef struct packed {
		logic [3:0] kind;
		logic [15:0] addr;
		logic [31:0] data; // Write data, poll mask, pin level or idle cycles
		logic [31:0] exp;
	} entry_t;

	logic aclk;
	logic rst_n_i;
	csr_req_t reg_i;
	csr_rsp_t reg_o;
	logic intr_o;
	logic rst_req_o;
	logic phy_reset_o;
	logic mdc_o;
	logic mdio_o;
	logic mdio_oe_o;
	logic mdio_i;
	logic phy_int_i;

	entry_t tbl[$];
	logic table_ready;
	logic [31:0] lfsr_state;
	int fail_count;
	logic [15:0] phy_init [32]; // PHY register contents before any write
	logic [15:0] phy_wr [32];
	logic wr_valid [32];
	logic [4:0] last_phyad;

	nic_top dut0 (
		.aclk(aclk), .rst_n_i(rst_n_i), .reg_i(reg_i), .reg_o(reg_o),
		.intr_o(intr_o), .rst_req_o(rst_req_o), .phy_reset_o(phy_reset_o),
		.mdc_o(mdc_o), .mdio_o(mdio_o), .mdio_oe_o(mdio_oe_o),
		.mdio_i(mdio_i), .phy_int_i(phy_int_i)
	);

	always #(CLK_PERIOD / 2) aclk = ~aclk;

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] draw_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < nbits; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic report_fail(input string msg);
		fail_count++;
		$display("FAIL %0t: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic write_reg(input logic [15:0] offset, input logic [31:0] value);
		@(negedge aclk);
		reg_i = '{wr: 1'b1, rd: 1'b0, addr: offset, wdata: value};
		@(negedge aclk);
		reg_i = '0;
	endtask

	task automatic read_reg(input logic [15:0] offset, output logic [31:0] value);
		@(negedge aclk);
		reg_i = '{wr: 1'b0, rd: 1'b1, addr: offset, wdata: 32'h0};
		@(negedge aclk);
		reg_i = '0;
		assert (reg_o.rvalid) else report_fail("no read data valid one cycle after the strobe");
		value = reg_o.rdata;
	endtask

	task automatic add_entry(input logic [3:0] kind, input logic [15:0] addr,
		input logic [31:0] data, input logic [31:0] exp);
		tbl.push_back({kind, addr, data, exp});
	endtask

	task automatic build_table();
		logic [31:0] r_bit;
		logic [31:0] ctrl_val;
		logic [31:0] ics_val;
		logic [31:0] mdic_wr;
		logic [31:0] mdic_rd;
		logic [4:0] regad_w;
		logic [4:0] regad_r;
		logic [15:0] wdata_w;
		r_bit = 32'h1 << `NIC_MDIC_R_BIT;
		ctrl_val = draw_bits(32);
		ics_val = draw_bits(32) | 32'h1;
		regad_w = 5'(draw_bits(5));
		regad_r = regad_w ^ 5'h01; // Never written so it holds its initial value
		wdata_w = 16'(draw_bits(16));
		mdic_wr = {4'b0000, `NIC_MDIC_OP_WRITE, `NIC_PHY_ADDR, regad_w, wdata_w};
		mdic_rd = {4'b0000, `NIC_MDIC_OP_READ, `NIC_PHY_ADDR, regad_r, 16'h0000};
		add_entry(K_RD, `NIC_REG_STATUS, 32'h0, `NIC_STATUS_VALUE);
		add_entry(K_WR, `NIC_REG_CTRL, ctrl_val, 32'h0);
		add_entry(K_RD, `NIC_REG_CTRL, 32'h0, ctrl_val);
		add_entry(K_PINS, 16'h0, 32'h0,
			{30'h0, ctrl_val[`NIC_CTRL_PHY_RST_BIT], ctrl_val[`NIC_CTRL_RST_BIT]});
		add_entry(K_WR, `NIC_REG_CTRL, 32'h1 << `NIC_CTRL_RST_BIT, 32'h0);
		add_entry(K_PINS, 16'h0, 32'h0, 32'h1);
		add_entry(K_WR, `NIC_REG_CTRL, 32'h1 << `NIC_CTRL_PHY_RST_BIT, 32'h0);
		add_entry(K_PINS, 16'h0, 32'h0, 32'h2);
		add_entry(K_WR, `NIC_REG_CTRL, 32'h0, 32'h0);
		add_entry(K_PINS, 16'h0, 32'h0, 32'h0);
		// Software causes and the mask
		add_entry(K_WR, `NIC_REG_ICS, ics_val, 32'h0);
		add_entry(K_INTR, 16'h0, 32'h0, 32'h0);
		add_entry(K_WR, `NIC_REG_IMS, 32'h1, 32'h0);
		add_entry(K_INTR, 16'h0, 32'h0, 32'h1);
		add_entry(K_RD, `NIC_REG_IMS, 32'h0, 32'h1);
		add_entry(K_WR, `NIC_REG_IMC, 32'h1, 32'h0);
		add_entry(K_INTR, 16'h0, 32'h0, 32'h0);
		add_entry(K_RD, `NIC_REG_ICR, 32'h0, ics_val);
		add_entry(K_RD, `NIC_REG_ICR, 32'h0, 32'h0);
		// PHY write, then PHY read
		add_entry(K_WR, `NIC_REG_IMS, 32'h1 << `NIC_ICR_MDAC_BIT, 32'h0);
		add_entry(K_WR, `NIC_REG_MDIC, mdic_wr, 32'h0);
		add_entry(K_POLL, `NIC_REG_MDIC, r_bit, 32'h0);
		add_entry(K_RD, `NIC_REG_MDIC, 32'h0, mdic_wr | r_bit);
		add_entry(K_PHY, {11'h0, regad_w}, 32'h0, {16'h0, wdata_w});
		add_entry(K_INTR, 16'h0, 32'h0, 32'h1);
		add_entry(K_RD, `NIC_REG_ICR, 32'h0, 32'h1 << `NIC_ICR_MDAC_BIT);
		add_entry(K_INTR, 16'h0, 32'h0, 32'h0);
		add_entry(K_WR, `NIC_REG_MDIC, mdic_rd, 32'h0);
		add_entry(K_POLL, `NIC_REG_MDIC, r_bit, 32'h0);
		add_entry(K_RD, `NIC_REG_MDIC, 32'h0, mdic_rd | r_bit | {16'h0, phy_init[regad_r]});
		add_entry(K_RD, `NIC_REG_ICR, 32'h0, 32'h1 << `NIC_ICR_MDAC_BIT);
		add_entry(K_WR, `NIC_REG_IMC, 32'h1 << `NIC_ICR_MDAC_BIT, 32'h0);
		// PHY interrupt pin
		add_entry(K_PIN, 16'h0, 32'h1, 32'h0);
		add_entry(K_IDLE, 16'h0, 32'd3, 32'h0);
		add_entry(K_RD, `NIC_REG_ICR, 32'h0, 32'h1 << `NIC_ICR_PHYINT_BIT);
		add_entry(K_INTR, 16'h0, 32'h0, 32'h0);
		add_entry(K_WR, `NIC_REG_IMS, 32'h1 << `NIC_ICR_PHYINT_BIT, 32'h0);
		add_entry(K_INTR, 16'h0, 32'h0, 32'h1);
		add_entry(K_PIN, 16'h0, 32'h0, 32'h0);
		add_entry(K_IDLE, 16'h0, 32'd3, 32'h0);
		add_entry(K_RD, `NIC_REG_ICR, 32'h0, 32'h1 << `NIC_ICR_PHYINT_BIT);
		add_entry(K_RD, `NIC_REG_ICR, 32'h0, 32'h0);
		add_entry(K_INTR, 16'h0, 32'h0, 32'h0);
	endtask

	// PHY model counting MDC rises over the preamble and the frame
	initial begin : phy_model
		int n;
		logic mdc_prev;
		logic rd_frame;
		logic oe_exp;
		logic [15:0] rd_val;
		logic [31:0] frame_sh;
		mdio_i = 1'b1;
		n = 0;
		mdc_prev = 1'b0;
		rd_frame = 1'b0;
		oe_exp = 1'b1;
		rd_val = '0;
		frame_sh = '0;
		last_phyad = '0;
		for (int i = 0; i < 32; i++) begin
			phy_wr[5'(i)] = '0;
			wr_valid[5'(i)] = 1'b0;
		end
		forever begin
			@(negedge aclk);
			if (mdc_o && !mdc_prev) begin
				oe_exp = !(rd_frame && n >= 46); // Released from TA in a read
				assert (mdio_oe_o == oe_exp) else report_fail($sformatf(
					"mdio_oe_o is %0b at MDC rise %0d, expected %0b", mdio_oe_o, n, oe_exp));
				frame_sh = {frame_sh[30:0], mdio_o};
				if (n == 45 && frame_sh[13:10] == {2'b01, `NIC_MDIC_OP_READ}
					&& frame_sh[9:5] == `NIC_PHY_ADDR) begin
					rd_frame = 1'b1;
					rd_val = wr_valid[frame_sh[4:0]] ? phy_wr[frame_sh[4:0]]
						: phy_init[frame_sh[4:0]];
				end
				if (n == 63) begin
					if (frame_sh[31:28] == {2'b01, `NIC_MDIC_OP_WRITE}) begin
						last_phyad = frame_sh[27:23];
						if (frame_sh[27:23] == `NIC_PHY_ADDR) begin
							phy_wr[frame_sh[22:18]] = frame_sh[15:0];
							wr_valid[frame_sh[22:18]] = 1'b1;
						end
					end
					rd_frame = 1'b0;
					n = 0;
				end else begin
					n++;
				end
			end else if (!mdc_o && mdc_prev) begin
				if (rd_frame && n == 47) begin
					mdio_i = 1'b0; // Second TA bit
				end else if (rd_frame && n >= 48) begin
					mdio_i = rd_val[4'(63 - n)];
				end else begin
					mdio_i = 1'b1; // Pull-up
				end
			end
			mdc_prev = mdc_o;
		end
	end

	initial begin : stimulus
		entry_t e;
		logic [31:0] got;
		aclk = 1'b0;
		rst_n_i = 1'b0;
		reg_i = '0;
		phy_int_i = 1'b0;
		fail_count = 0;
		table_ready = 1'b0;
		lfsr_state = 32'd44;
		for (int i = 0; i < 32; i++) begin
			phy_init[5'(i)] = 16'(draw_bits(16));
		end
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge aclk);
		@(negedge aclk);
		rst_n_i = 1'b1;
		for (int i = 0; i < tbl.size(); i++) begin
			e = tbl[i];
			case (e.kind)
				K_WR: write_reg(e.addr, e.data);
				K_RD: begin
					read_reg(e.addr, got);
					assert (got == e.exp) else report_fail($sformatf(
						"read of 0x%04h returned 0x%08h, expected 0x%08h", e.addr, got, e.exp));
				end
				K_POLL: begin
					got = '0;
					while ((got & e.data) == 0) begin
						read_reg(e.addr, got);
					end
				end
				K_INTR: assert (intr_o == e.exp[0]) else report_fail($sformatf(
					"intr_o is %0b, expected %0b", intr_o, e.exp[0]));
				K_PINS: assert ({phy_reset_o, rst_req_o} == e.exp[1:0]) else report_fail(
					$sformatf("phy_reset_o, rst_req_o are %0b%0b, expected %02b",
					phy_reset_o, rst_req_o, e.exp[1:0]));
				K_PHY: assert (wr_valid[e.addr[4:0]] && phy_wr[e.addr[4:0]] == e.exp[15:0]
					&& last_phyad == `NIC_PHY_ADDR) else report_fail($sformatf(
					"PHY register %0d holds 0x%04h from PHY address %0d, expected 0x%04h",
					e.addr[4:0], phy_wr[e.addr[4:0]], last_phyad, e.exp[15:0]));
				K_PIN: begin
					@(negedge aclk);
					phy_int_i = e.data[0];
				end
				K_IDLE: repeat (e.data) @(negedge aclk);
				default: report_fail("unknown entry kind in the stimulus table");
			endcase
		end
		if (fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Each entry gets 70 MDC periods
	initial begin : watchdog
		wait (table_ready);
		repeat (tbl.size() * 70 * 2 * `NIC_MDC_DIV + 16) @(posedge aclk);
		$display("Timeout: the tests did not finish within the time limit");
		$display("Testbench failed");
		$fatal(1);
	end
endmodule

// ==== source/nic_top.sv ====
`timescale 1ns/10ps

module nic_top (
	input  logic aclk,
	input  logic rst_n_i,
	input  nic_pkg::csr_req_t reg_i,
	output nic_pkg::csr_rsp_t reg_o,
	output logic intr_o,
	output logic rst_req_o,
	output logic phy_reset_o,
	output logic mdc_o,
	output logic mdio_o,
	output logic mdio_oe_o,
	input  logic mdio_i,
	input  logic phy_int_i
);
	import nic_pkg::*;

	intr_wr_t intr_wr;
	mdio_cmd_t mdio_cmd;
	mdio_res_t mdio_res;
	logic [31:0] icr;
	logic [31:0] ims;

	csr_regs csr_regs0 (
		.aclk(aclk), .rst_n_i(rst_n_i),
		.csr_i(reg_i), .csr_o(reg_o),
		.icr_i(icr), .ims_i(ims),
		.intr_wr_o(intr_wr),
		.mdio_cmd_o(mdio_cmd), .mdio_res_i(mdio_res),
		.rst_req_o(rst_req_o), .phy_reset_o(phy_reset_o)
	);

	intr_ctrl intr_ctrl0 (
		.aclk(aclk), .rst_n_i(rst_n_i),
		.intr_wr_i(intr_wr),
		.mdac_i(mdio_res.done), // Access complete is the MDAC cause
		.phy_int_i(phy_int_i),
		.icr_o(icr), .ims_o(ims),
		.intr_o(intr_o)
	);

	mdio_master mdio_master0 (
		.aclk(aclk), .rst_n_i(rst_n_i),
		.cmd_i(mdio_cmd), .res_o(mdio_res),
		.mdc_o(mdc_o), .mdio_o(mdio_o), .mdio_oe_o(mdio_oe_o),
		.mdio_i(mdio_i)
	);
endmodule

// ==== source/mdio_master.sv ====
`timescale 1ns/10ps
`include "nic_config.svh"

module mdio_master (
	input  logic aclk,
	input  logic rst_n_i,
	input  nic_pkg::mdio_cmd_t cmd_i,
	output nic_pkg::mdio_res_t res_o,
	output logic mdc_o,
	output logic mdio_o,
	output logic mdio_oe_o,
	input  logic mdio_i
);
	import nic_pkg::*;

	localparam int DIV_W = $clog2(`NIC_MDC_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`NIC_MDC_DIV - 1);

	logic [DIV_W-1:0] div_q;
	logic mdc_q;
	logic busy_q;
	logic rd_op_q;
	logic oe_q;
	logic done_q;
	logic [5:0] bit_q; // Bits 0..31 preamble, 32..63 frame
	logic [15:0] rdata_q;
	logic tick;
	logic rise;
	logic fall;
	mdio_frame_u frame_d;
	mdio_frame_u frame_q;

	assign tick = busy_q && (div_q == DIV_LAST);
	assign rise = tick && !mdc_q;
	assign fall = tick && mdc_q;

	always_comb begin
		frame_d.fields.st = 2'b01;
		frame_d.fields.op = cmd_i.op;
		frame_d.fields.phyad = `NIC_PHY_ADDR;
		frame_d.fields.regad = cmd_i.regad;
		frame_d.fields.ta = 2'b10;
		frame_d.fields.data = (cmd_i.op == `NIC_MDIC_OP_READ) ? 16'h0000 : cmd_i.wdata;
	end

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			div_q <= '0;
			mdc_q <= 1'b0;
			bit_q <= '0;
			oe_q <= 1'b0;
			rd_op_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (cmd_i.start) begin
				busy_q <= 1'b1;
				div_q <= '0;
				mdc_q <= 1'b0;
				bit_q <= '0;
				oe_q <= 1'b1;
				rd_op_q <= cmd_i.op == `NIC_MDIC_OP_READ;
			end else if (busy_q) begin
				div_q <= tick ? '0 : div_q + 1'b1;
				if (tick) begin
					mdc_q <= !mdc_q;
				end
				if (fall) begin
					bit_q <= bit_q + 1'b1;
					if (bit_q == 6'd63) begin
						busy_q <= 1'b0;
						oe_q <= 1'b0;
						done_q <= 1'b1;
					end else if (rd_op_q && bit_q == 6'd45) begin
						oe_q <= 1'b0; // PHY owns the line from TA
					end
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (cmd_i.start) begin
			frame_q <= frame_d;
		end else if (fall && bit_q[5]) begin
			frame_q.bits <= {frame_q.bits[30:0], 1'b0};
		end
		if (rise && rd_op_q && bit_q >= 6'd48) begin
			rdata_q <= {rdata_q[14:0], mdio_i}; // MSB first
		end
	end

	assign mdc_o = mdc_q;
	assign mdio_o = bit_q[5] ? frame_q.bits[31] : 1'b1;
	assign mdio_oe_o = oe_q;
	assign res_o = '{done: done_q, rdata: rdata_q};

	a_no_start_busy: assert property (@(posedge aclk) disable iff (!rst_n_i)
		cmd_i.start |-> !busy_q)
		else $error("mdio_master: start while an access is running");
endmodule

// ==== source/intr_ctrl.sv ====
`timescale 1ns/10ps
`include "nic_config.svh"

module intr_ctrl (
	input  logic aclk,
	input  logic rst_n_i,
	input  nic_pkg::intr_wr_t intr_wr_i,
	input  logic mdac_i,
	input  logic phy_int_i,
	output logic [31:0] icr_o,
	output logic [31:0] ims_o,
	output logic intr_o
);
	logic [1:0] phy_sync_q;
	logic [31:0] cause_set;
	logic [31:0] icr_d;
	logic [31:0] icr_q;
	logic [31:0] ims_d;
	logic [31:0] ims_q;
	logic intr_q;

	// Two-flop synchronizer for the PHY pin
	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			phy_sync_q <= 2'b00;
		end else begin
			phy_sync_q <= {phy_sync_q[0], phy_int_i};
		end
	end

	always_comb begin
		cause_set = intr_wr_i.ics_set ? intr_wr_i.wdata : 32'h0;
		cause_set[`NIC_ICR_MDAC_BIT] = cause_set[`NIC_ICR_MDAC_BIT] | mdac_i;
		cause_set[`NIC_ICR_PHYINT_BIT] = cause_set[`NIC_ICR_PHYINT_BIT] | phy_sync_q[1];
		// New causes win over read-to-clear
		icr_d = (intr_wr_i.icr_rd ? 32'h0 : icr_q) | cause_set;
		ims_d = ims_q;
		if (intr_wr_i.ims_set) begin
			ims_d = ims_q | intr_wr_i.wdata;
		end else if (intr_wr_i.imc_set) begin
			ims_d = ims_q & ~intr_wr_i.wdata;
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			icr_q <= '0;
			ims_q <= '0;
			intr_q <= 1'b0;
		end else begin
			icr_q <= icr_d;
			ims_q <= ims_d;
			intr_q <= |(icr_d & ims_d);
		end
	end

	assign icr_o = icr_q;
	assign ims_o = ims_q;
	assign intr_o = intr_q;

	// Rises only after a new cause or a mask bit set
	a_intr_rise: assert property (@(posedge aclk) disable iff (!rst_n_i)
		$rose(intr_o) |-> $past(intr_wr_i.ics_set || intr_wr_i.ims_set || mdac_i
		|| phy_sync_q[1]))
		else $error("intr_ctrl: interrupt rose without a new cause or unmask");
endmodule

// ==== source/csr_regs.sv ====
`timescale 1ns/10ps
`include "nic_config.svh"

module csr_regs (
	input  logic aclk,
	input  logic rst_n_i,
	input  nic_pkg::csr_req_t csr_i,
	output nic_pkg::csr_rsp_t csr_o,
	input  logic [31:0] icr_i,
	input  logic [31:0] ims_i,
	output nic_pkg::intr_wr_t intr_wr_o,
	output nic_pkg::mdio_cmd_t mdio_cmd_o,
	input  nic_pkg::mdio_res_t mdio_res_i,
	output logic rst_req_o,
	output logic phy_reset_o
);
	logic [31:0] ctrl_q;
	logic [31:0] mdic_q;
	logic [31:0] rd_mux;
	logic [31:0] rdata_q;
	logic rvalid_q;
	logic sel_ctrl;
	logic sel_mdic;
	logic sel_icr;
	logic sel_ics;
	logic sel_ims;
	logic sel_imc;
	logic mdic_start;

	assign sel_ctrl = csr_i.addr == `NIC_REG_CTRL;
	assign sel_mdic = csr_i.addr == `NIC_REG_MDIC;
	assign sel_icr = csr_i.addr == `NIC_REG_ICR;
	assign sel_ics = csr_i.addr == `NIC_REG_ICS;
	assign sel_ims = csr_i.addr == `NIC_REG_IMS;
	assign sel_imc = csr_i.addr == `NIC_REG_IMC;

	// Only accepted when no access is running
	assign mdic_start = csr_i.wr && sel_mdic && mdic_q[`NIC_MDIC_R_BIT];

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			ctrl_q <= '0;
		end else if (csr_i.wr && sel_ctrl) begin
			ctrl_q <= csr_i.wdata;
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			mdic_q <= 32'h1 << `NIC_MDIC_R_BIT; // Ready out of reset
		end else if (mdio_res_i.done) begin
			mdic_q[`NIC_MDIC_R_BIT] <= 1'b1;
			if (mdic_q[27:26] == `NIC_MDIC_OP_READ) begin
				mdic_q[15:0] <= mdio_res_i.rdata;
			end
		end else if (mdic_start) begin
			mdic_q <= {4'b0000, csr_i.wdata[27:0]}; // R drops while busy
		end
	end

	always_comb begin
		case (csr_i.addr)
			`NIC_REG_CTRL:   rd_mux = ctrl_q;
			`NIC_REG_STATUS: rd_mux = `NIC_STATUS_VALUE;
			`NIC_REG_MDIC:   rd_mux = mdic_q;
			`NIC_REG_ICR:    rd_mux = icr_i;
			`NIC_REG_IMS:    rd_mux = ims_i;
			default:         rd_mux = '0; // ICS, IMC and holes
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= csr_i.rd;
		end
	end

	always_ff @(posedge aclk) begin
		if (csr_i.rd) begin
			rdata_q <= rd_mux;
		end
	end

	assign csr_o = '{rvalid: rvalid_q, rdata: rdata_q};

	assign intr_wr_o = '{
		ics_set: csr_i.wr && sel_ics,
		ims_set: csr_i.wr && sel_ims,
		imc_set: csr_i.wr && sel_imc,
		icr_rd: csr_i.rd && sel_icr,
		wdata: csr_i.wdata
	};

	// MDIC fields straight from the write data
	assign mdio_cmd_o = '{
		start: mdic_start,
		op: csr_i.wdata[27:26],
		regad: csr_i.wdata[20:16],
		wdata: csr_i.wdata[15:0]
	};

	assign rst_req_o = ctrl_q[`NIC_CTRL_RST_BIT];
	assign phy_reset_o = ctrl_q[`NIC_CTRL_PHY_RST_BIT] || !rst_n_i;

	a_no_wr_rd: assert property (@(posedge aclk) disable iff (!rst_n_i)
		!(csr_i.wr && csr_i.rd))
		else $error("csr_regs: write and read strobe in one cycle");
endmodule

// ==== source/nic_pkg.sv ====
package nic_pkg;

	typedef struct packed {
		logic wr;
		logic rd;
		logic [15:0] addr;
		logic [31:0] wdata;
	} csr_req_t;

	typedef struct packed {
		logic rvalid;
		logic [31:0] rdata;
	} csr_rsp_t;

	typedef struct packed {
		logic start;
		logic [1:0] op;
		logic [4:0] regad;
		logic [15:0] wdata;
	} mdio_cmd_t;

	typedef struct packed {
		logic done;
		logic [15:0] rdata;
	} mdio_res_t;

	typedef struct packed {
		logic ics_set;
		logic ims_set;
		logic imc_set;
		logic icr_rd;
		logic [31:0] wdata;
	} intr_wr_t;

	// Clause 22 frame, built by fields and shifted out as bits
	typedef union packed {
		struct packed {
			logic [1:0] st;
			logic [1:0] op;
			logic [4:0] phyad;
			logic [4:0] regad;
			logic [1:0] ta;
			logic [15:0] data;
		} fields;
		logic [31:0] bits;
	} mdio_frame_u;
endpackage

// ==== source/nic_config.svh ====
`ifndef NIC_CONFIG_SVH
`define NIC_CONFIG_SVH

// Register byte offsets
`define NIC_REG_CTRL    16'h0000
`define NIC_REG_STATUS  16'h0008
`define NIC_REG_MDIC    16'h0020
`define NIC_REG_ICR     16'h00C0
`define NIC_REG_ICS     16'h00C8
`define NIC_REG_IMS     16'h00D0
`define NIC_REG_IMC     16'h00D8

`define NIC_CTRL_RST_BIT      26
`define NIC_CTRL_PHY_RST_BIT  31
`define NIC_MDIC_R_BIT        28
`define NIC_MDIC_OP_WRITE     2'b01
`define NIC_MDIC_OP_READ      2'b10
`define NIC_ICR_MDAC_BIT      9
`define NIC_ICR_PHYINT_BIT    12
`define NIC_PHY_ADDR          5'd0
`define NIC_MDC_DIV           4 // Half MDC period in aclk cycles
`define NIC_STATUS_VALUE      32'h0000_0283 // FD, LU, 1000 Mb/s
`endif
